//--- Bender.yml
package:
  name: oflow_registration

sources:
  - hdl/oflow_core_pkg.sv
  - hdl/oflow_reg_types_pkg.sv
  - hdl/oflow_credit_buffer.sv
  - hdl/oflow_set_intake.sv
  - hdl/oflow_score_calc.sv
  - hdl/oflow_registration_fsm_score_board.sv
  - hdl/oflow_score_board.sv
  - hdl/oflow_registration_top.sv
  - target: test
    files:
      - test/oflow_registration_assert.sv
      - test/oflow_registration_tb.sv

//--- hdl/oflow_core_pkg.sv
// sizing constants for frames, sets, descriptors, credits and the match threshold
package oflow_core_pkg;

	// ----------------------------------------------------------------------
	// frame and set sizing
	// ----------------------------------------------------------------------

	// frame counter width
	localparam int TOTAL_FRAME_NUM_WIDTH = 8;
	// set counts and indices, up to 15 sets per frame
	localparam int SET_LEN = 4;
	// one reference entry per set index
	localparam int MAX_SETS = 16;

	// ----------------------------------------------------------------------
	// descriptor and score sizing
	// ----------------------------------------------------------------------

	localparam int DESC_LANES = 4;
	localparam int LANE_WIDTH = 8;
	// sad of four 8-bit lanes fits in 10 bits
	localparam int SCORE_WIDTH = 10;
	// running total over a frame
	localparam int TOTAL_WIDTH = 14;

	// ----------------------------------------------------------------------
	// flow control and matching
	// ----------------------------------------------------------------------

	// input fifo depth, also credits handed to the sender at reset
	localparam int IN_DEPTH = 4;
	// result credits held by the dut at reset
	localparam int RES_CREDITS = 2;
	// match when score strictly below this
	localparam int MATCH_THRESH = 64;

endpackage

//--- hdl/oflow_credit_buffer.sv
// credit-counted circular fifo, payload type set by parameter
`timescale 1ns/1ns

module oflow_credit_buffer #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input  logic     clk,
	input  logic     reset_N,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t pop_data,
	output logic     not_empty,
	output logic     credit
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// ----------------------------------------------------------------------
	// storage and pointers
	// ----------------------------------------------------------------------

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_pop;

	// pop ignored on empty
	assign do_pop = pop && not_empty;
	assign not_empty = (count != '0);
	// head is read straight from the array
	assign pop_data = mem[rd_ptr];
	// one credit back per item leaving
	assign credit = do_pop;

	// no reset on the data array
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// wrap at depth, not at a power of two
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(push) - CNT_W'(do_pop);
		end
	end

endmodule

//--- hdl/oflow_reg_types_pkg.sv
// packed structs for descriptor sets, calc requests and result records
package oflow_reg_types_pkg;

	// one descriptor, lane 0 in the low byte
	typedef logic [oflow_core_pkg::DESC_LANES-1:0][oflow_core_pkg::LANE_WIDTH-1:0] desc_t;

	// arriving set, 44 bits
	typedef struct packed {
		logic [oflow_core_pkg::TOTAL_FRAME_NUM_WIDTH-1:0] frame_num;
		logic [oflow_core_pkg::SET_LEN-1:0] set_idx;
		desc_t desc;
	} desc_set_t;

	// decoded set handed from intake to calc and score board
	typedef struct packed {
		desc_set_t set;
		logic first_frame;
		logic last_set;
	} calc_req_t;

	// one outgoing result record
	typedef struct packed {
		logic [oflow_core_pkg::TOTAL_FRAME_NUM_WIDTH-1:0] frame_num;
		logic [oflow_core_pkg::SET_LEN-1:0] set_idx;
		logic [oflow_core_pkg::SCORE_WIDTH-1:0] score;
		logic matched;
		logic first_frame;
		logic last_set;
		// only meaningful with last_set
		logic [oflow_core_pkg::TOTAL_WIDTH-1:0] frame_total;
	} reg_result_t;

endpackage

//--- hdl/oflow_registration_fsm_score_board.sv
// registration fsm that starts the score board per set for both frame paths
`timescale 1ns/1ns

module oflow_registration_fsm_score_board (
	input  logic clk,
	input  logic reset_N,
	// from intake
	input  logic [oflow_core_pkg::TOTAL_FRAME_NUM_WIDTH-1:0] frame_num,
	input  logic [oflow_core_pkg::SET_LEN-1:0] num_of_sets,
	input  logic start_registration,
	input  logic [oflow_core_pkg::SET_LEN-1:0] counter_of_sets,
	// from score calc
	input  logic done_score_calc,
	// score board handshake
	input  logic done_score_board,
	output logic start_score_board,
	output logic [oflow_core_pkg::SET_LEN-1:0] counter_first_frame_sets
);

	// ----------------------------------------------------------------------
	// state register
	// ----------------------------------------------------------------------

	typedef enum logic [2:0] {
		idle_st,
		score_board_st,
		wait_st,
		score_board_first_frame_st,
		wait_first_frame_st
	} sm_type_t;

	sm_type_t current_state;
	sm_type_t next_state;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			current_state <= idle_st;
		else
			current_state <= next_state;
	end

	// frame 0 sets started after the first one
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			counter_first_frame_sets <= '0;
		else if (current_state == idle_st)
			counter_first_frame_sets <= '0;
		else if (current_state == wait_first_frame_st &&
				next_state == score_board_first_frame_st)
			counter_first_frame_sets <= counter_first_frame_sets + 1'b1;
	end

	// ----------------------------------------------------------------------
	// next state and start strobe
	// ----------------------------------------------------------------------

	always_comb begin
		next_state = current_state;
		start_score_board = 1'b0;
		case (current_state)
			idle_st: begin
				// later frames start straight off the calc result
				if (done_score_calc && frame_num != '0) begin
					next_state = score_board_st;
					start_score_board = 1'b1;
				end else if (start_registration && frame_num == '0) begin
					next_state = score_board_first_frame_st;
				end
			end
			score_board_st: begin
				// leave once the whole frame has been started
				if (counter_of_sets == num_of_sets)
					next_state = idle_st;
				else
					next_state = wait_st;
			end
			wait_st: begin
				if (done_score_calc) begin
					next_state = score_board_st;
					start_score_board = 1'b1;
				end
			end
			score_board_first_frame_st: begin
				// strobe one cycle after start_registration
				start_score_board = 1'b1;
				next_state = wait_first_frame_st;
			end
			wait_first_frame_st: begin
				if (start_registration && counter_first_frame_sets < num_of_sets - 1'b1)
					next_state = score_board_first_frame_st;
				// last frame 0 record out, back to idle
				else if (done_score_board && counter_first_frame_sets == num_of_sets - 1'b1)
					next_state = idle_st;
			end
			default: next_state = idle_st;
		endcase
	end

endmodule

//--- hdl/oflow_registration_top.sv
// registration top with input and result credit buffers and the four stages
`timescale 1ns/1ns

module oflow_registration_top (
	input  logic clk,
	input  logic reset_N,
	input  logic [oflow_core_pkg::SET_LEN-1:0] num_of_sets,
	// input credit interface
	input  logic in_valid,
	input  oflow_reg_types_pkg::desc_set_t in_set,
	output logic in_credit,
	// result credit interface
	output logic res_valid,
	output oflow_reg_types_pkg::reg_result_t res_data,
	input  logic res_credit
);

	// ----------------------------------------------------------------------
	// internal wiring
	// ----------------------------------------------------------------------

	oflow_reg_types_pkg::desc_set_t pop_data;
	oflow_reg_types_pkg::calc_req_t calc_req;
	oflow_reg_types_pkg::reg_result_t sb_data;
	logic in_avail, in_pop, busy, set_in_flight, sb_busy, sb_valid, res_avail;
	logic calc_start, start_registration, done_score_calc;
	logic start_score_board, done_score_board;
	logic [oflow_core_pkg::TOTAL_FRAME_NUM_WIDTH-1:0] frame_num;
	logic [oflow_core_pkg::SET_LEN-1:0] counter_of_sets;
	logic [oflow_core_pkg::SCORE_WIDTH-1:0] score;

	// one set past intake until its record is out
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			set_in_flight <= 1'b0;
		else if (calc_start)
			set_in_flight <= 1'b1;
		else if (done_score_board)
			set_in_flight <= 1'b0;
	end

	assign busy = set_in_flight || sb_busy;

	oflow_credit_buffer #(
		.payload_t(oflow_reg_types_pkg::desc_set_t),
		.DEPTH(oflow_core_pkg::IN_DEPTH)
	) u_in_buf (.clk, .reset_N, .push(in_valid), .push_data(in_set), .pop(in_pop),
		.pop_data, .not_empty(in_avail), .credit(in_credit));

	oflow_set_intake u_intake (.clk, .reset_N, .not_empty(in_avail), .pop_data,
		.pop(in_pop), .busy, .num_of_sets, .calc_start, .calc_req, .start_registration,
		.frame_num, .counter_of_sets);

	oflow_score_calc u_calc (.clk, .reset_N, .calc_start, .calc_req, .done_score_calc, .score);

	oflow_registration_fsm_score_board u_fsm (.clk, .reset_N, .frame_num, .num_of_sets,
		.start_registration, .counter_of_sets, .done_score_calc, .done_score_board,
		.start_score_board, .counter_first_frame_sets());

	oflow_score_board u_board (.clk, .reset_N, .start_score_board, .calc_req, .score,
		.res_credit, .res_valid(sb_valid), .res_data(sb_data), .done_score_board,
		.busy(sb_busy));

	// drains every cycle, the pop pulse is the outgoing valid
	oflow_credit_buffer #(
		.payload_t(oflow_reg_types_pkg::reg_result_t),
		.DEPTH(oflow_core_pkg::RES_CREDITS)
	) u_res_buf (.clk, .reset_N, .push(sb_valid), .push_data(sb_data), .pop(res_avail),
		.pop_data(res_data), .not_empty(res_avail), .credit(res_valid));

endmodule

//--- hdl/oflow_score_board.sv
// result stage building records, match flag and frame total under result credits
`timescale 1ns/1ns

module oflow_score_board (
	input  logic clk,
	input  logic reset_N,
	input  logic start_score_board,
	input  oflow_reg_types_pkg::calc_req_t calc_req,
	input  logic [oflow_core_pkg::SCORE_WIDTH-1:0] score,
	// credits returned by the receiver
	input  logic res_credit,
	output logic res_valid,
	output oflow_reg_types_pkg::reg_result_t res_data,
	output logic done_score_board,
	output logic busy
);

	localparam int CRED_W = $clog2(oflow_core_pkg::RES_CREDITS + 1);

	logic hold;
	logic [CRED_W-1:0] credits;
	logic [oflow_core_pkg::TOTAL_WIDTH-1:0] total_q;
	logic [oflow_core_pkg::SCORE_WIDTH-1:0] eff_score;
	logic [oflow_core_pkg::TOTAL_WIDTH-1:0] new_total;

	// ----------------------------------------------------------------------
	// record build
	// ----------------------------------------------------------------------

	// frame 0 has nothing to compare against
	assign eff_score = calc_req.first_frame ? '0 : score;
	assign new_total = total_q + oflow_core_pkg::TOTAL_WIDTH'(eff_score);

	always_ff @(posedge clk) begin
		if (start_score_board) begin
			res_data.frame_num <= calc_req.set.frame_num;
			res_data.set_idx <= calc_req.set.set_idx;
			res_data.score <= eff_score;
			res_data.matched <= !calc_req.first_frame && (score < oflow_core_pkg::MATCH_THRESH);
			res_data.first_frame <= calc_req.first_frame;
			res_data.last_set <= calc_req.last_set;
			res_data.frame_total <= calc_req.last_set ? new_total : '0;
		end
	end

	// ----------------------------------------------------------------------
	// send and credit tracking
	// ----------------------------------------------------------------------

	// record leaves only with a credit in hand
	assign res_valid = hold && (credits != '0);
	assign done_score_board = res_valid;
	assign busy = hold;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			hold <= 1'b0;
			credits <= CRED_W'(oflow_core_pkg::RES_CREDITS);
			total_q <= '0;
		end else begin
			if (start_score_board) begin
				hold <= 1'b1;
				// running sum restarts after the last set
				total_q <= calc_req.last_set ? '0 : new_total;
			end else if (res_valid) begin
				hold <= 1'b0;
			end
			credits <= credits + CRED_W'(res_credit) - CRED_W'(res_valid);
		end
	end

endmodule

//--- hdl/oflow_score_calc.sv
// execute stage with reference descriptor memory and two-stage sad pipeline
`timescale 1ns/1ns

module oflow_score_calc (
	input  logic clk,
	input  logic reset_N,
	input  logic calc_start,
	input  oflow_reg_types_pkg::calc_req_t calc_req,
	output logic done_score_calc,
	output logic [oflow_core_pkg::SCORE_WIDTH-1:0] score
);

	// ----------------------------------------------------------------------
	// reference memory and pipeline registers
	// ----------------------------------------------------------------------

	// one descriptor per set index from the previous frame
	oflow_reg_types_pkg::desc_t ref_mem [oflow_core_pkg::MAX_SETS];

	// per lane absolute differences
	logic [oflow_core_pkg::DESC_LANES-1:0][oflow_core_pkg::LANE_WIDTH-1:0] diff_q;
	logic s1_valid;

	// ----------------------------------------------------------------------
	// stage one, lane differences and reference update
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		oflow_reg_types_pkg::desc_t old_desc;
		oflow_reg_types_pkg::desc_t new_desc;
		old_desc = ref_mem[calc_req.set.set_idx];
		new_desc = calc_req.set.desc;
		if (calc_start) begin
			for (int i = 0; i < oflow_core_pkg::DESC_LANES; i++) begin
				// abs without a sign bit
				if (new_desc[i] >= old_desc[i])
					diff_q[i] <= new_desc[i] - old_desc[i];
				else
					diff_q[i] <= old_desc[i] - new_desc[i];
			end
			// read of the old entry happens before this lands
			ref_mem[calc_req.set.set_idx] <= new_desc;
		end
	end

	// ----------------------------------------------------------------------
	// stage two, lane sum
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		logic [oflow_core_pkg::SCORE_WIDTH-1:0] sum;
		sum = '0;
		for (int i = 0; i < oflow_core_pkg::DESC_LANES; i++)
			sum = sum + oflow_core_pkg::SCORE_WIDTH'(diff_q[i]);
		if (s1_valid)
			score <= sum;
	end

	// frame 0 only stores, so no done strobe
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			s1_valid <= 1'b0;
			done_score_calc <= 1'b0;
		end else begin
			s1_valid <= calc_start && !calc_req.first_frame;
			done_score_calc <= s1_valid;
		end
	end

endmodule

//--- hdl/oflow_set_intake.sv
// decode stage that pops sets, flags first frame and last set, counts sets
`timescale 1ns/1ns

module oflow_set_intake (
	input  logic clk,
	input  logic reset_N,
	// input fifo
	input  logic not_empty,
	input  oflow_reg_types_pkg::desc_set_t pop_data,
	output logic pop,
	// pipeline hold from top
	input  logic busy,
	input  logic [oflow_core_pkg::SET_LEN-1:0] num_of_sets,
	// to score calc and score board
	output logic calc_start,
	output oflow_reg_types_pkg::calc_req_t calc_req,
	// to registration fsm
	output logic start_registration,
	output logic [oflow_core_pkg::TOTAL_FRAME_NUM_WIDTH-1:0] frame_num,
	output logic [oflow_core_pkg::SET_LEN-1:0] counter_of_sets
);

	// ----------------------------------------------------------------------
	// pop decision
	// ----------------------------------------------------------------------

	// calc_start covers the cycle before busy rises
	assign pop = not_empty && !busy && !calc_start;

	assign frame_num = calc_req.set.frame_num;

	// held until the next pop, score board reads it later
	always_ff @(posedge clk) begin
		if (pop) begin
			calc_req.set <= pop_data;
			calc_req.first_frame <= (pop_data.frame_num == '0);
			calc_req.last_set <= (pop_data.set_idx == num_of_sets - 1'b1);
		end
	end

	// ----------------------------------------------------------------------
	// strobes and set counter
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			calc_start <= 1'b0;
			start_registration <= 1'b0;
			counter_of_sets <= '0;
		end else begin
			// calc always runs so the reference gets written
			calc_start <= pop;
			// fsm only needs the kick on frame 0
			start_registration <= pop && (pop_data.frame_num == '0);
			if (pop) begin
				// restart at one after a full frame
				if (counter_of_sets == num_of_sets)
					counter_of_sets <= 4'd1;
				else
					counter_of_sets <= counter_of_sets + 1'b1;
			end
		end
	end

endmodule

//--- test/oflow_registration_assert.sv
// concurrent assertions on result credits, input fill, score board strobe and calc latency
`timescale 1ns/1ns

module oflow_registration_assert (
	input logic clk,
	input logic reset_N,
	input logic res_valid,
	input logic res_credit,
	input logic in_valid,
	input logic in_credit,
	input logic start_score_board,
	input logic calc_start,
	input oflow_reg_types_pkg::calc_req_t calc_req,
	input logic done_score_calc
);

	// result credits the dut holds at its output
	int res_held;
	// input fifo fill
	int in_fill;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			res_held <= oflow_core_pkg::RES_CREDITS;
			in_fill <= 0;
		end else begin
			res_held <= res_held + int'(res_credit) - int'(res_valid);
			in_fill <= in_fill + int'(in_valid) - int'(in_credit);
		end
	end

	send_with_credit: assert property (@(posedge clk) disable iff (!reset_N)
		res_valid |-> res_held > 0) else $error("result sent with no credit held");
	no_in_overflow: assert property (@(posedge clk) disable iff (!reset_N)
		in_valid |-> in_fill < oflow_core_pkg::IN_DEPTH) else $error("input fifo overflow");
	start_single: assert property (@(posedge clk) disable iff (!reset_N)
		start_score_board |=> !start_score_board) else $error("start strobe held");
	calc_latency: assert property (@(posedge clk) disable iff (!reset_N)
		calc_start && !calc_req.first_frame |-> ##2 done_score_calc)
		else $error("calc done not two cycles after start");

endmodule

bind oflow_registration_top oflow_registration_assert u_assert (.clk, .reset_N,
	.res_valid, .res_credit, .in_valid, .in_credit, .start_score_board,
	.calc_start, .calc_req, .done_score_calc);

//--- test/oflow_registration_tb.sv
// testbench for the registration top with xorshift stimulus, reference model and credit checks
`timescale 1ns/1ns

module oflow_registration_tb;

	localparam int NUM_FRAMES = 6;
	localparam int NUM_SETS = 5;
	localparam int TOTAL_SETS = NUM_FRAMES * NUM_SETS;
	// per-set budget covers the result credit stalls
	localparam int TIMEOUT_CYCLES = 60 * TOTAL_SETS + 500;
	// quiet cycles after the last result to catch duplicates
	localparam int DRAIN_CYCLES = 20;

	logic clk;
	logic reset_N;
	logic [oflow_core_pkg::SET_LEN-1:0] num_of_sets;
	logic in_valid;
	oflow_reg_types_pkg::desc_set_t in_set;
	logic in_credit;
	logic res_valid;
	oflow_reg_types_pkg::reg_result_t res_data;
	logic res_credit;

	// ----------------------------------------------------------------------
	// model and sender state
	// ----------------------------------------------------------------------

	logic [31:0] rng_state;
	oflow_reg_types_pkg::desc_set_t stim [TOTAL_SETS];
	// previous frame descriptor per set index
	oflow_reg_types_pkg::desc_t ref_desc [NUM_SETS];
	oflow_reg_types_pkg::reg_result_t exp_q [$];
	string name_q [$];
	int tx_credits;
	int sent;
	int received;
	int credit_pulses;
	// result credits owed back to the dut
	int pending_ret;
	int stall;
	int cycles;
	int drain;

	oflow_registration_top dut (.clk, .reset_N, .num_of_sets, .in_valid, .in_set,
		.in_credit, .res_valid, .res_data, .res_credit);

	always #20 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// lane-wise sum of absolute differences
	function automatic int lane_sad(oflow_reg_types_pkg::desc_t a, oflow_reg_types_pkg::desc_t b);
		int sum;
		sum = 0;
		for (int i = 0; i < oflow_core_pkg::DESC_LANES; i++)
			sum += (a[i] >= b[i]) ? int'(a[i]) - int'(b[i]) : int'(b[i]) - int'(a[i]);
		return sum;
	endfunction

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compare_result(string name, oflow_reg_types_pkg::reg_result_t expected,
			oflow_reg_types_pkg::reg_result_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s expected %h (score %0d total %0d) actual %h (score %0d total %0d)",
				name, expected, expected.score, expected.frame_total,
				actual, actual.score, actual.frame_total);
			abort_run();
		end
	endtask

	task automatic compare_credits(string name, int unsigned expected, int unsigned actual);
		if (actual != expected) begin
			$display("[ERROR] %s expected %0d actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	// ----------------------------------------------------------------------
	// stimulus and expected results built up front
	// ----------------------------------------------------------------------

	task automatic build_stimulus();
		oflow_reg_types_pkg::desc_t d;
		oflow_reg_types_pkg::reg_result_t r;
		logic [31:0] rnd;
		int score;
		int total;
		int span;
		string kind;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			total = 0;
			// frames 1-2 random, 3-4 close to reference, 5 straddles the threshold
			if (f == 0)
				kind = "frame0_reference";
			else if (f < 3)
				kind = "random_sad";
			else if (f < 5)
				kind = "near_match";
			else
				kind = "threshold_mix";
			span = (f == 5) ? 32 : 16;
			for (int s = 0; s < NUM_SETS; s++) begin
				for (int i = 0; i < oflow_core_pkg::DESC_LANES; i++) begin
					rnd = next_rand();
					if (f < 3)
						d[i] = rnd[7:0];
					// step away from the reference without wrapping
					else if (ref_desc[s][i] >= 8'd128)
						d[i] = ref_desc[s][i] - 8'(rnd % span);
					else
						d[i] = ref_desc[s][i] + 8'(rnd % span);
				end
				score = (f == 0) ? 0 : lane_sad(d, ref_desc[s]);
				ref_desc[s] = d;
				total += score;
				stim[f * NUM_SETS + s].frame_num = 8'(f);
				stim[f * NUM_SETS + s].set_idx = 4'(s);
				stim[f * NUM_SETS + s].desc = d;
				r.frame_num = 8'(f);
				r.set_idx = 4'(s);
				r.score = oflow_core_pkg::SCORE_WIDTH'(score);
				r.matched = (f != 0) && (score < oflow_core_pkg::MATCH_THRESH);
				r.first_frame = (f == 0);
				r.last_set = (s == NUM_SETS - 1);
				r.frame_total = r.last_set ? oflow_core_pkg::TOTAL_WIDTH'(total) : '0;
				exp_q.push_back(r);
				name_q.push_back($sformatf("%s f%0d s%0d", kind, f, s));
			end
		end
	endtask

	task automatic drive_inputs();
		logic [31:0] rnd;
		in_valid = 1'b0;
		res_credit = 1'b0;
		// sender pauses now and then and never sends without a credit
		rnd = next_rand();
		if (sent < TOTAL_SETS && tx_credits > 0 && rnd[1:0] != 2'b00) begin
			in_valid = 1'b1;
			in_set = stim[sent];
			sent++;
			tx_credits--;
		end
		// result credits withheld for random stretches
		rnd = next_rand();
		if (stall > 0)
			stall--;
		else if (rnd[2:0] == 3'b000)
			stall = int'(rnd[7:4]);
		else if (pending_ret > 0) begin
			res_credit = 1'b1;
			pending_ret--;
		end
	endtask

	// sampled mid-cycle once outputs have settled
	task automatic sample_outputs();
		oflow_reg_types_pkg::reg_result_t expected;
		string name;
		if (in_credit) begin
			credit_pulses++;
			tx_credits++;
		end
		if (tx_credits > oflow_core_pkg::IN_DEPTH) begin
			$display("input credits returned beyond the buffer depth");
			abort_run();
		end
		if (res_valid) begin
			if (exp_q.size() == 0) begin
				$display("a result arrived when none was expected");
				abort_run();
			end else begin
				expected = exp_q.pop_front();
				name = name_q.pop_front();
				compare_result(name, expected, res_data);
				received++;
				pending_ret++;
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		reset_N = 1'b0;
		num_of_sets = 4'(NUM_SETS);
		in_valid = 1'b0;
		in_set = '0;
		res_credit = 1'b0;
		rng_state = 32'h6cbc4a41;
		tx_credits = oflow_core_pkg::IN_DEPTH;
		sent = 0;
		received = 0;
		credit_pulses = 0;
		pending_ret = 0;
		stall = 0;
		cycles = 0;
		drain = 0;
		build_stimulus();
		repeat (4) @(posedge clk);
		#2 reset_N = 1'b1;
		while (received < TOTAL_SETS || drain < DRAIN_CYCLES) begin
			@(posedge clk);
			#2;
			drive_inputs();
			@(negedge clk);
			sample_outputs();
			cycles++;
			if (received == TOTAL_SETS)
				drain++;
			if (cycles >= TIMEOUT_CYCLES) begin
				$display("timeout after %0d cycles, %0d of %0d results received",
					cycles, received, TOTAL_SETS);
				abort_run();
			end
		end
		// every set sent must have been popped exactly once
		if (credit_pulses == sent) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			compare_credits("in_credit_total", sent, credit_pulses);
		end
	end

endmodule

//--- verilog.f
hdl/oflow_core_pkg.sv
hdl/oflow_reg_types_pkg.sv
hdl/oflow_credit_buffer.sv
hdl/oflow_set_intake.sv
hdl/oflow_score_calc.sv
hdl/oflow_registration_fsm_score_board.sv
hdl/oflow_score_board.sv
hdl/oflow_registration_top.sv
test/oflow_registration_assert.sv
test/oflow_registration_tb.sv
